// ==== sources.f ====
vcache_prof_pkg.sv
vcache_op_classifier.sv
vcache_fill_monitor.sv
vcache_stat_bank.sv
vcache_stat_readout.sv
vcache_profiler.sv
vcache_profiler_tb.sv

// ==== vcache_profiler_testdata.txt ====
# C rsp_v rsp_yumi miss op_class op_attr mask dma_v dma_yumi dma_wnr fill way valid dirty (hex)
# R select expected_count (decimal); op_class 0 other, 1 load, 2 store, 3 atomic
# every counter right after reset, only idle has moved
R 0 0
R 1 0
R 2 0
R 3 0
R 4 0
R 5 0
R 6 0
R 7 0
R 8 0
R 9 0
R 10 0
R 11 0
R 12 0
R 13 0
R 14 0
R 15 0
R 16 0
R 17 0
R 18 0
R 19 77
R 20 0
R 21 0
R 22 0
R 23 0
R 24 0
R 25 0
# loads lw lwu lh lhu lb lbu, op_attr is {sigext, size}
C 1 1 0 1 6 0 0 0 0 0 0 0 0
C 1 1 0 1 2 0 0 0 0 0 0 0 0
C 1 1 0 1 5 0 0 0 0 0 0 0 0
C 1 1 0 1 1 0 0 0 0 0 0 0 0
C 1 1 0 1 4 0 0 0 0 0 0 0 0
C 1 1 0 1 0 0 0 0 0 0 0 0 0
# stores by mask, three lanes counts only as a store
C 1 1 0 2 0 f 0 0 0 0 0 0 0
C 1 1 0 2 0 3 0 0 0 0 0 0 0
C 1 1 0 2 0 1 0 0 0 0 0 0 0
C 1 1 0 2 0 7 0 0 0 0 0 0 0
# responses held off with yumi low
C 1 0 0 1 6 0 0 0 0 0 0 0 0
C 1 0 0 2 0 f 0 0 0 0 0 0 0
# atomics swap, or, add; attr 4 and 1 above counted as lb and lhu
C 1 1 0 3 0 0 0 0 0 0 0 0 0
C 1 1 0 3 4 0 0 0 0 0 0 0 0
C 1 1 0 3 1 0 0 0 0 0 0 0 0
C 1 1 0 0 0 0 0 0 0 0 0 0 0
# miss handler busy, alone, with each class accepted, with a stall
C 0 0 1 0 0 0 0 0 0 0 0 0 0
C 1 1 1 1 6 0 0 0 0 0 0 0 0
C 1 1 1 2 0 f 0 0 0 0 0 0 0
C 1 1 1 3 1 0 0 0 0 0 0 0 0
C 1 0 1 1 6 0 0 0 0 0 0 0 0
# quiet cycles, DMA packets and fills with invalid, clean and dirty victims
C 0 0 0 0 0 0 0 0 0 0 0 0 0
C 0 1 0 1 6 0 0 0 0 0 0 0 0
C 0 0 0 0 0 0 1 1 0 0 0 0 0
C 0 0 0 0 0 0 1 1 1 0 0 0 0
C 0 0 0 0 0 0 1 0 1 0 0 0 0
C 0 0 0 0 0 0 0 0 0 1 2 b 1
C 0 0 0 0 0 0 0 0 0 1 0 f 2
C 0 0 0 0 0 0 0 0 0 1 3 f 8
C 1 1 0 1 2 0 1 1 1 1 1 3 2
# every counter again
R 0 8
R 1 2
R 2 2
R 3 1
R 4 1
R 5 1
R 6 1
R 7 5
R 8 2
R 9 1
R 10 1
R 11 4
R 12 1
R 13 1
R 14 2
R 15 1
R 16 1
R 17 1
R 18 5
R 19 189
R 20 3
R 21 1
R 22 2
R 23 1
R 24 1
R 25 2

// ==== vcache_profiler_tb.sv ====
// Testbench for the vcache profiler. Replays per-cycle event stimulus and
// counter reads from vcache_profiler_testdata.txt, runs each read as a full
// four-phase handshake and compares the returned count with the file.

`default_nettype none

module vcache_profiler_tb;

  localparam int ACK_WAIT = 8; // cycles allowed per handshake phase

  logic                                   clk;
  logic                                   reset;
  logic                                   rsp_v;
  logic                                   rsp_yumi;
  logic                                   miss;
  vcache_prof_pkg::op_class_e             op_class;
  vcache_prof_pkg::op_attr_u              op_attr;
  logic [vcache_prof_pkg::MASK_WIDTH-1:0] mask;
  logic                                   dma_pkt_v;
  logic                                   dma_pkt_yumi;
  logic                                   dma_write_not_read;
  logic                                   fill_done;
  logic [vcache_prof_pkg::LG_WAYS-1:0]    chosen_way;
  logic [vcache_prof_pkg::WAYS-1:0]       way_valid;
  logic [vcache_prof_pkg::WAYS-1:0]       way_dirty;
  logic                                   stat_req;
  logic [vcache_prof_pkg::SEL_WIDTH-1:0]  stat_sel;
  logic                                   stat_ack;
  logic [vcache_prof_pkg::STAT_WIDTH-1:0] stat_data;

  string lines [$];  // whole data file, one entry per line
  int    line_count;
  bit    file_loaded;
  int    error_count;
  int    check_count;

  vcache_profiler vcache_profiler_inst (
    .clk_i                (clk),
    .reset_i              (reset),
    .rsp_v_i              (rsp_v),
    .rsp_yumi_i           (rsp_yumi),
    .miss_i               (miss),
    .op_class_i           (op_class),
    .op_attr_i            (op_attr),
    .mask_i               (mask),
    .dma_pkt_v_i          (dma_pkt_v),
    .dma_pkt_yumi_i       (dma_pkt_yumi),
    .dma_write_not_read_i (dma_write_not_read),
    .fill_done_i          (fill_done),
    .chosen_way_i         (chosen_way),
    .way_valid_i          (way_valid),
    .way_dirty_i          (way_dirty),
    .stat_req_i           (stat_req),
    .stat_sel_i           (stat_sel),
    .stat_ack_o           (stat_ack),
    .stat_data_o          (stat_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic compare_values(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("MISMATCH at time %0t: %s, got %0d, expected %0d",
               $time, what, actual, expected);
    end
  endtask

  task automatic quiet_inputs();
    rsp_v              <= 1'b0;
    rsp_yumi           <= 1'b0;
    miss               <= 1'b0;
    op_class           <= vcache_prof_pkg::OP_OTHER;
    op_attr            <= '0;
    mask               <= '0;
    dma_pkt_v          <= 1'b0;
    dma_pkt_yumi       <= 1'b0;
    dma_write_not_read <= 1'b0;
    fill_done          <= 1'b0;
    chosen_way         <= '0;
    way_valid          <= '0;
    way_dirty          <= '0;
  endtask

  // one C line holds every event input for a single cycle
  task automatic apply_cycle(input string text, input int line_no);
    int         fields;
    logic [3:0] v, yumi, mis, cls, attr, msk;
    logic [3:0] dv, dyumi, dwnr;
    logic [3:0] fdone, way, vld, drt;
    fields = $sscanf(text, "C %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     v, yumi, mis, cls, attr, msk, dv, dyumi, dwnr, fdone, way, vld, drt);
    if (fields != 13) begin
      error_count++;
      $display("line %0d: cycle line has %0d fields instead of 13", line_no, fields);
    end else begin
      @(posedge clk);
      rsp_v              <= v[0];
      rsp_yumi           <= yumi[0];
      miss               <= mis[0];
      op_class           <= vcache_prof_pkg::op_class_e'(cls[1:0]);
      op_attr            <= attr[2:0]; // sign/size or sub-op, by class
      mask               <= msk;
      dma_pkt_v          <= dv[0];
      dma_pkt_yumi       <= dyumi[0];
      dma_write_not_read <= dwnr[0];
      fill_done          <= fdone[0];
      chosen_way         <= way[vcache_prof_pkg::LG_WAYS-1:0];
      way_valid          <= vld;
      way_dirty          <= drt;
    end
  endtask

  // full four-phase read, event inputs held low throughout
  task automatic read_counter(input int sel, input logic [31:0] expected, input int line_no);
    int          waited;
    logic [31:0] held;
    @(posedge clk);
    quiet_inputs();
    stat_sel <= sel[vcache_prof_pkg::SEL_WIDTH-1:0];
    stat_req <= 1'b1;
    @(negedge clk);
    compare_values(stat_ack, 1'b0, $sformatf("line %0d: ack before req was seen", line_no));
    waited = 0;
    while (stat_ack !== 1'b1 && waited < ACK_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (stat_ack !== 1'b1) begin
      error_count++;
      $display("line %0d: no ack within %0d cycles of the request", line_no, ACK_WAIT);
    end else begin
      compare_values(stat_data, expected, $sformatf("line %0d: counter %0d", line_no, sel));
    end
    held = stat_data;
    @(posedge clk);
    stat_req <= 1'b0;
    @(negedge clk);
    compare_values(stat_ack, 1'b1, $sformatf("line %0d: ack fell before req", line_no));
    waited = 0;
    while (stat_ack !== 1'b0 && waited < ACK_WAIT) begin
      compare_values(stat_data, held, $sformatf("line %0d: data moved under ack", line_no));
      @(negedge clk);
      waited++;
    end
    if (stat_ack !== 1'b0) begin
      error_count++;
      $display("line %0d: ack still high %0d cycles after req was dropped", line_no, ACK_WAIT);
    end
  endtask

  task automatic finish_run();
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  initial begin
    int          fd;
    int          line_no;
    int          sel;
    logic [31:0] expected;
    string       text;
    reset    = 1'b1;
    stat_req = 1'b0;
    stat_sel = '0;
    quiet_inputs();
    fd = $fopen("vcache_profiler_testdata.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("could not open vcache_profiler_testdata.txt for reading");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(text, fd) != 0) begin
          lines.push_back(text);
        end
      end
      $fclose(fd);
    end
    line_count  = lines.size();
    file_loaded = 1'b1;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    compare_values(stat_ack, 1'b0, "ack after reset");
    compare_values(stat_data, 32'd0, "data after reset");
    for (line_no = 1; line_no <= line_count; line_no++) begin
      text = lines[line_no-1];
      if (text.len() > 0) begin
        case (text.getc(0))
          "C": apply_cycle(text, line_no);
          "R": begin
            if ($sscanf(text, "R %d %d", sel, expected) == 2) begin
              read_counter(sel, expected, line_no);
            end else begin
              error_count++;
              $display("line %0d: read line needs a select and a count", line_no);
            end
          end
          "#", " ", "\n", "\r": ; // comment or blank
          default: begin
            error_count++;
            $display("line %0d: unknown command in the data file", line_no);
          end
        endcase
      end
    end
    finish_run();
  end

  // budget grows with the length of the data file
  initial begin
    wait (file_loaded);
    repeat (line_count * 20 + 200) @(posedge clk);
    error_count++;
    $display("watchdog expired after %0d cycles, the run did not complete",
             line_count * 20 + 200);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== vcache_profiler.sv ====
// Performance counter block for the non-blocking data cache.
// Attach the event inputs to the cache response, miss and DMA ports,
// then read any counter through the stat req/ack port.

`default_nettype none

module vcache_profiler (
  input  logic                                  clk_i,
  input  logic                                  reset_i,

  // response port and decode
  input  logic                                  rsp_v_i,
  input  logic                                  rsp_yumi_i,
  input  logic                                  miss_i,
  input  vcache_prof_pkg::op_class_e            op_class_i,
  input  vcache_prof_pkg::op_attr_u             op_attr_i,
  input  logic [vcache_prof_pkg::MASK_WIDTH-1:0] mask_i,

  // DMA port and fill state
  input  logic                                  dma_pkt_v_i,
  input  logic                                  dma_pkt_yumi_i,
  input  logic                                  dma_write_not_read_i,
  input  logic                                  fill_done_i,
  input  logic [vcache_prof_pkg::LG_WAYS-1:0]    chosen_way_i,
  input  logic [vcache_prof_pkg::WAYS-1:0]       way_valid_i,
  input  logic [vcache_prof_pkg::WAYS-1:0]       way_dirty_i,

  // counter read port
  input  logic                                  stat_req_i,
  input  logic [vcache_prof_pkg::SEL_WIDTH-1:0]  stat_sel_i,
  output logic                                  stat_ack_o,
  output logic [vcache_prof_pkg::STAT_WIDTH-1:0] stat_data_o
);

  logic [vcache_prof_pkg::NUM_EVENTS-1:0] op_ev;
  logic [vcache_prof_pkg::NUM_EVENTS-1:0] fill_ev;
  logic [vcache_prof_pkg::NUM_EVENTS-1:0] ev;
  logic [vcache_prof_pkg::STAT_WIDTH-1:0] count [vcache_prof_pkg::NUM_EVENTS];

  vcache_op_classifier op_classifier_inst (
    .rsp_v_i    (rsp_v_i),
    .rsp_yumi_i (rsp_yumi_i),
    .miss_i     (miss_i),
    .op_class_i (op_class_i),
    .op_attr_i  (op_attr_i),
    .mask_i     (mask_i),
    .op_ev_o    (op_ev)
  );

  vcache_fill_monitor fill_monitor_inst (
    .dma_pkt_v_i          (dma_pkt_v_i),
    .dma_pkt_yumi_i       (dma_pkt_yumi_i),
    .dma_write_not_read_i (dma_write_not_read_i),
    .fill_done_i          (fill_done_i),
    .chosen_way_i         (chosen_way_i),
    .way_valid_i          (way_valid_i),
    .way_dirty_i          (way_dirty_i),
    .fill_ev_o            (fill_ev)
  );

  assign ev = op_ev | fill_ev; // the two slices never overlap

  vcache_stat_bank stat_bank_inst (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .ev_i    (ev),
    .count_o (count)
  );

  vcache_stat_readout stat_readout_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .stat_req_i  (stat_req_i),
    .stat_sel_i  (stat_sel_i),
    .count_i     (count),
    .stat_ack_o  (stat_ack_o),
    .stat_data_o (stat_data_o)
  );

endmodule

`default_nettype wire

// ==== vcache_stat_readout.sv ====
// Four-phase req/ack read port for the counter bank.
// A request snapshots the selected counter; the value holds until the next request.

`default_nettype none

module vcache_stat_readout (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic                                  stat_req_i,
  input  logic [vcache_prof_pkg::SEL_WIDTH-1:0]  stat_sel_i,
  input  logic [vcache_prof_pkg::STAT_WIDTH-1:0] count_i [vcache_prof_pkg::NUM_EVENTS],
  output logic                                  stat_ack_o,
  output logic [vcache_prof_pkg::STAT_WIDTH-1:0] stat_data_o
);

  logic                                  ack_r;  // the one state bit of the handshake
  logic [vcache_prof_pkg::STAT_WIDTH-1:0] data_r;
  logic [vcache_prof_pkg::STAT_WIDTH-1:0] sel_count;

  // out of range selects read as zero
  assign sel_count = (stat_sel_i < vcache_prof_pkg::NUM_EVENTS) ? count_i[stat_sel_i] : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_r  <= 1'b0;
      data_r <= '0;
    end else if (stat_req_i && !ack_r) begin
      ack_r  <= 1'b1;      // new request
      data_r <= sel_count; // value from before this edge
    end else if (!stat_req_i && ack_r) begin
      ack_r <= 1'b0;       // host released req
    end
  end

  assign stat_ack_o  = ack_r;
  assign stat_data_o = data_r;

  // host keeps the select steady for as long as req is held
  sel_stable_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    stat_req_i |=> (!stat_req_i || $stable(stat_sel_i))
  ) else $error("stat_sel_i changed while stat_req_i was held");

  sel_in_range_a: assert property (
    @(posedge clk_i) disable iff (reset_i)
    stat_req_i |-> (stat_sel_i < vcache_prof_pkg::NUM_EVENTS)
  ) else $error("stat_sel_i %0d has no counter", stat_sel_i);

endmodule

`default_nettype wire

// ==== vcache_stat_bank.sv ====
// Bank of free-running event counters, one per event vector bit.
// All counters clear on reset and wrap silently at 2^STAT_WIDTH.

`default_nettype none

module vcache_stat_bank (
  input  logic                                  clk_i,
  input  logic                                  reset_i,
  input  logic [vcache_prof_pkg::NUM_EVENTS-1:0] ev_i,
  output logic [vcache_prof_pkg::STAT_WIDTH-1:0] count_o [vcache_prof_pkg::NUM_EVENTS]
);

  logic [vcache_prof_pkg::STAT_WIDTH-1:0] count_r [vcache_prof_pkg::NUM_EVENTS];

  for (genvar i = 0; i < vcache_prof_pkg::NUM_EVENTS; i++) begin : g_counter
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        count_r[i] <= '0;
      end else if (ev_i[i]) begin
        count_r[i] <= count_r[i] + 1'b1; // at most one per cycle
      end
    end
  end

  // every counter is visible at once, the readout picks one
  assign count_o = count_r;

endmodule

`default_nettype wire

// ==== vcache_fill_monitor.sv ====
// Turns DMA packet handshakes and fill completions into DMA and replacement
// events. Combinational; only the DMA and replacement bits are driven.

`default_nettype none

module vcache_fill_monitor (
  input  logic                                  dma_pkt_v_i,
  input  logic                                  dma_pkt_yumi_i,
  input  logic                                  dma_write_not_read_i,
  input  logic                                  fill_done_i,
  input  logic [vcache_prof_pkg::LG_WAYS-1:0]    chosen_way_i,
  input  logic [vcache_prof_pkg::WAYS-1:0]       way_valid_i,
  input  logic [vcache_prof_pkg::WAYS-1:0]       way_dirty_i,
  output logic [vcache_prof_pkg::NUM_EVENTS-1:0] fill_ev_o
);

  logic pkt_fire;
  logic victim_valid;
  logic victim_dirty;

  assign pkt_fire     = dma_pkt_v_i & dma_pkt_yumi_i; // packet taken by the DMA engine
  assign victim_valid = way_valid_i[chosen_way_i];
  assign victim_dirty = way_dirty_i[chosen_way_i];

  always_comb begin
    fill_ev_o = '0; // classifier bits stay low

    fill_ev_o[vcache_prof_pkg::EV_DMA_RD] = pkt_fire & ~dma_write_not_read_i;
    fill_ev_o[vcache_prof_pkg::EV_DMA_WR] = pkt_fire & dma_write_not_read_i;

    // one of three victim kinds per completed fill
    fill_ev_o[vcache_prof_pkg::EV_REPL_INV]   = fill_done_i & ~victim_valid;
    fill_ev_o[vcache_prof_pkg::EV_REPL_VALID] = fill_done_i & victim_valid & ~victim_dirty;
    fill_ev_o[vcache_prof_pkg::EV_REPL_DIRTY] = fill_done_i & victim_valid & victim_dirty;
  end

  // the cache's stat memory may only mark a line dirty while it is valid
  dirty_implies_valid_a: assert final ((fill_done_i & victim_dirty) !== 1'b1 || victim_valid)
    else $error("fill victim way %0d is dirty but not valid", chosen_way_i);

endmodule

`default_nettype wire

// ==== vcache_op_classifier.sv ====
// Sorts the cache response port and miss state into per-cycle events.
// Purely combinational; drives only the request, miss, idle and stall bits.

`default_nettype none

module vcache_op_classifier (
  input  logic                                  rsp_v_i,
  input  logic                                  rsp_yumi_i,
  input  logic                                  miss_i,
  input  vcache_prof_pkg::op_class_e            op_class_i,
  input  vcache_prof_pkg::op_attr_u             op_attr_i,
  input  logic [vcache_prof_pkg::MASK_WIDTH-1:0] mask_i,
  output logic [vcache_prof_pkg::NUM_EVENTS-1:0] op_ev_o
);

  logic accept;
  logic is_ld;
  logic is_st;
  logic is_amo;
  logic [$clog2(vcache_prof_pkg::MASK_WIDTH+1)-1:0] mask_ones;
  logic amo_legal;

  assign accept = rsp_v_i & rsp_yumi_i; // response leaves the cache this cycle
  assign is_ld  = (op_class_i == vcache_prof_pkg::OP_LOAD);
  assign is_st  = (op_class_i == vcache_prof_pkg::OP_STORE);
  assign is_amo = (op_class_i == vcache_prof_pkg::OP_ATOMIC);

  // number of enabled byte lanes of a masked store
  always_comb begin
    mask_ones = '0;
    for (int i = 0; i < vcache_prof_pkg::MASK_WIDTH; i++) begin
      mask_ones = mask_ones + mask_i[i];
    end
  end

  assign amo_legal = (op_attr_i.amo == vcache_prof_pkg::AMO_SWAP)
                   | (op_attr_i.amo == vcache_prof_pkg::AMO_OR)
                   | (op_attr_i.amo == vcache_prof_pkg::AMO_ADD);

  always_comb begin
    op_ev_o = '0; // fill monitor bits stay low

    // loads use the size and sign view of the attribute
    op_ev_o[vcache_prof_pkg::EV_LD]  = accept & is_ld;
    op_ev_o[vcache_prof_pkg::EV_LW]  = accept & is_ld & op_attr_i.ld.sigext
                                     & (op_attr_i.ld.size == vcache_prof_pkg::SIZE_WORD);
    op_ev_o[vcache_prof_pkg::EV_LWU] = accept & is_ld & ~op_attr_i.ld.sigext
                                     & (op_attr_i.ld.size == vcache_prof_pkg::SIZE_WORD);
    op_ev_o[vcache_prof_pkg::EV_LH]  = accept & is_ld & op_attr_i.ld.sigext
                                     & (op_attr_i.ld.size == vcache_prof_pkg::SIZE_HALF);
    op_ev_o[vcache_prof_pkg::EV_LHU] = accept & is_ld & ~op_attr_i.ld.sigext
                                     & (op_attr_i.ld.size == vcache_prof_pkg::SIZE_HALF);
    op_ev_o[vcache_prof_pkg::EV_LB]  = accept & is_ld & op_attr_i.ld.sigext
                                     & (op_attr_i.ld.size == vcache_prof_pkg::SIZE_BYTE);
    op_ev_o[vcache_prof_pkg::EV_LBU] = accept & is_ld & ~op_attr_i.ld.sigext
                                     & (op_attr_i.ld.size == vcache_prof_pkg::SIZE_BYTE);

    // stores are sized by their mask only
    op_ev_o[vcache_prof_pkg::EV_ST] = accept & is_st;
    op_ev_o[vcache_prof_pkg::EV_SW] = accept & is_st & (mask_ones == 3'd4);
    op_ev_o[vcache_prof_pkg::EV_SH] = accept & is_st & (mask_ones == 3'd2);
    op_ev_o[vcache_prof_pkg::EV_SB] = accept & is_st & (mask_ones == 3'd1);

    // atomics use the sub-op view of the same word
    op_ev_o[vcache_prof_pkg::EV_AMO]     = accept & is_amo;
    op_ev_o[vcache_prof_pkg::EV_AMOSWAP] = accept & is_amo
                                         & (op_attr_i.amo == vcache_prof_pkg::AMO_SWAP);
    op_ev_o[vcache_prof_pkg::EV_AMOOR]   = accept & is_amo
                                         & (op_attr_i.amo == vcache_prof_pkg::AMO_OR);
    op_ev_o[vcache_prof_pkg::EV_AMOADD]  = accept & is_amo
                                         & (op_attr_i.amo == vcache_prof_pkg::AMO_ADD);

    op_ev_o[vcache_prof_pkg::EV_MISS_LD]  = accept & miss_i & is_ld;
    op_ev_o[vcache_prof_pkg::EV_MISS_ST]  = accept & miss_i & is_st;
    op_ev_o[vcache_prof_pkg::EV_MISS_AMO] = accept & miss_i & is_amo;

    op_ev_o[vcache_prof_pkg::EV_MISS_CYC]  = miss_i;
    op_ev_o[vcache_prof_pkg::EV_IDLE]      = ~rsp_v_i & ~miss_i;
    op_ev_o[vcache_prof_pkg::EV_STALL_RSP] = rsp_v_i & ~rsp_yumi_i;
  end

  // the cache decoder must never hand back an unknown atomic
  amo_subop_legal_a: assert final ((accept & is_amo) !== 1'b1 || amo_legal)
    else $error("accepted atomic with illegal sub-op %b", op_attr_i.amo);

endmodule

`default_nettype wire

// ==== vcache_prof_pkg.sv ====
// Shared widths, event indices and operation encodings for the vcache profiler.
// Every profiler module refers to these by scoped names.

`default_nettype none

package vcache_prof_pkg;

  localparam int STAT_WIDTH = 32; // width of every event counter
  localparam int WAYS       = 4;
  localparam int LG_WAYS    = $clog2(WAYS);
  localparam int MASK_WIDTH = 4;  // one bit per byte of a 32-bit word

  // event vector bit positions, also the read select values
  localparam int EV_LD          = 0;  // all accepted loads
  localparam int EV_LW          = 1;
  localparam int EV_LWU         = 2;
  localparam int EV_LH          = 3;
  localparam int EV_LHU         = 4;
  localparam int EV_LB          = 5;
  localparam int EV_LBU         = 6;
  localparam int EV_ST          = 7;  // all accepted stores
  localparam int EV_SW          = 8;
  localparam int EV_SH          = 9;
  localparam int EV_SB          = 10;
  localparam int EV_AMO         = 11; // all accepted atomics
  localparam int EV_AMOSWAP     = 12;
  localparam int EV_AMOOR       = 13;
  localparam int EV_AMOADD      = 14;
  localparam int EV_MISS_LD     = 15;
  localparam int EV_MISS_ST     = 16;
  localparam int EV_MISS_AMO    = 17;
  localparam int EV_MISS_CYC    = 18; // cycles with the miss handler busy
  localparam int EV_IDLE        = 19;
  localparam int EV_STALL_RSP   = 20; // response held off by the network
  localparam int EV_DMA_RD      = 21;
  localparam int EV_DMA_WR      = 22;
  localparam int EV_REPL_INV    = 23;
  localparam int EV_REPL_VALID  = 24;
  localparam int EV_REPL_DIRTY  = 25;

  localparam int NUM_EVENTS = 26;
  localparam int SEL_WIDTH  = $clog2(NUM_EVENTS);

  typedef enum logic [1:0] {
    OP_OTHER  = 2'b00,
    OP_LOAD   = 2'b01,
    OP_STORE  = 2'b10,
    OP_ATOMIC = 2'b11
  } op_class_e;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } size_e;

  // same codes as the cache's own atomic decode
  typedef enum logic [2:0] {
    AMO_SWAP = 3'b000,
    AMO_ADD  = 3'b001,
    AMO_OR   = 3'b100
  } amo_subop_e;

  // one attribute word, read by the op class that travels with it
  typedef union packed {
    struct packed {
      logic  sigext; // sign extend the loaded value
      size_e size;
    } ld;
    amo_subop_e amo;
  } op_attr_u;

endpackage

`default_nettype wire
